/* Makefile */
# Verilator build and run of the Tiny86 flow tracker testbench

VERILATOR ?= verilator
TOP       ?= tiny86_flow_tb
FILELIST  ?= tiny86_flow.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= All tests passed!

SOURCES := $(shell grep -v '^+' $(FILELIST)) common/tiny86_settings.svh
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_MSG"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

test: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -Fqx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* cfu/cfu.sv */
// Tiny86 control flow unit
// Resolves the EIP following an instruction: sequential, relative
// transfer from the next EIP, or absolute target
`include "tiny86_settings.svh"

module cfu (
  input  tiny86_pkg::opc_t         opc,
  input  tiny86_pkg::eflags_t      eflags,
  input  logic                     ecx_is_zero,
  input  logic [`TINY86_EIP_W-1:0] eip,
  input  logic [`TINY86_LEN_W-1:0] instr_len,
  input  logic [`TINY86_EIP_W-1:0] address,
  output logic [`TINY86_EIP_W-1:0] next_eip,
  output logic                     taken
);

  logic                     cc_eval;
  logic                     always_xfer;
  logic                     xfer_abs;
  logic [`TINY86_EIP_W-1:0] seq_eip;
  logic [`TINY86_EIP_W-1:0] xfer_eip;

  // Condition check for Jcc and the loop family, zero for anything else
  always_comb begin
    case (opc)
      tiny86_pkg::CMD_JO:     cc_eval = eflags.of_;
      tiny86_pkg::CMD_JNO:    cc_eval = !eflags.of_;
      tiny86_pkg::CMD_JB:     cc_eval = eflags.cf_;
      tiny86_pkg::CMD_JAE:    cc_eval = !eflags.cf_;
      tiny86_pkg::CMD_JE:     cc_eval = eflags.zf_;
      tiny86_pkg::CMD_JNE:    cc_eval = !eflags.zf_;
      tiny86_pkg::CMD_JBE:    cc_eval = eflags.cf_ | eflags.zf_;
      tiny86_pkg::CMD_JA:     cc_eval = !eflags.cf_ & !eflags.zf_;
      tiny86_pkg::CMD_JS:     cc_eval = eflags.sf_;
      tiny86_pkg::CMD_JNS:    cc_eval = !eflags.sf_;
      tiny86_pkg::CMD_JP:     cc_eval = eflags.pf_;
      tiny86_pkg::CMD_JNP:    cc_eval = !eflags.pf_;
      // Signed compares look at SF against OF
      tiny86_pkg::CMD_JL:     cc_eval = eflags.sf_ != eflags.of_;
      tiny86_pkg::CMD_JNL:    cc_eval = eflags.sf_ == eflags.of_;
      tiny86_pkg::CMD_JLE:    cc_eval = eflags.zf_ | (eflags.sf_ != eflags.of_);
      tiny86_pkg::CMD_JG:     cc_eval = !eflags.zf_ & (eflags.sf_ == eflags.of_);
      // The host reports ECX after the LOOP decrement
      tiny86_pkg::CMD_JCXZ:   cc_eval = ecx_is_zero;
      tiny86_pkg::CMD_LOOP:   cc_eval = !ecx_is_zero;
      tiny86_pkg::CMD_LOOPE:  cc_eval = !ecx_is_zero & eflags.zf_;
      tiny86_pkg::CMD_LOOPNE: cc_eval = !ecx_is_zero & !eflags.zf_;
      default:                cc_eval = 1'b0;
    endcase
  end

  // Unconditional transfers and whether the target is absolute
  always_comb begin
    always_xfer = 1'b0;
    xfer_abs    = 1'b0;
    case (opc)
      tiny86_pkg::CMD_CALLr,
      tiny86_pkg::CMD_JMPr: begin
        always_xfer = 1'b1;
      end
      tiny86_pkg::CMD_CALLi,
      tiny86_pkg::CMD_JMPi,
      tiny86_pkg::CMD_RET: begin
        always_xfer = 1'b1;
        xfer_abs    = 1'b1;
      end
      default: begin
        always_xfer = 1'b0;
        xfer_abs    = 1'b0;
      end
    endcase
  end

  // Fall-through address, length is zero-extended
  assign seq_eip = eip + {{(`TINY86_EIP_W-`TINY86_LEN_W){1'b0}}, instr_len};

  // Relative displacements are taken from the fall-through address
  assign xfer_eip = xfer_abs ? address : seq_eip + address;

  assign taken    = cc_eval | always_xfer;
  assign next_eip = taken ? xfer_eip : seq_eip;

endmodule

/* common/flow_ctrl_if.sv */
// Control link between the APB register block and the EIP unit
// Carries redirects and clears one way and live state the other
`include "tiny86_settings.svh"

interface flow_ctrl_if;

  // Register block to unit, single-cycle pulses
  logic                     set_eip_valid;
  logic [`TINY86_EIP_W-1:0] set_eip;
  logic                     clr_counts;

  // Unit to register block, current architectural state
  logic [`TINY86_EIP_W-1:0] eip;
  logic [`TINY86_CNT_W-1:0] instr_count;
  logic [`TINY86_CNT_W-1:0] taken_count;

  modport regs (
    output set_eip_valid, set_eip, clr_counts,
    input  eip, instr_count, taken_count
  );

  modport unit (
    input  set_eip_valid, set_eip, clr_counts,
    output eip, instr_count, taken_count
  );

endinterface

/* common/tiny86_pkg.sv */
// Tiny86 shared types
// Opcodes, the EFLAGS layout and the issue and retire records
`include "tiny86_settings.svh"

package tiny86_pkg;

  // Decoded command set, only the control flow subset is told apart
  typedef enum logic [6:0] {
    CMD_NOP,
    CMD_ALU,
    // Conditional jumps, in x86 condition code order
    CMD_JO, CMD_JNO, CMD_JB, CMD_JAE,
    CMD_JE, CMD_JNE, CMD_JBE, CMD_JA,
    CMD_JS, CMD_JNS, CMD_JP, CMD_JNP,
    CMD_JL, CMD_JNL, CMD_JLE, CMD_JG,
    // Loop and count-register tests
    CMD_JCXZ,
    CMD_LOOP,
    CMD_LOOPE,
    CMD_LOOPNE,
    // Unconditional transfers, r is relative and i is absolute
    CMD_CALLr,
    CMD_CALLi,
    CMD_JMPr,
    CMD_JMPi,
    CMD_RET
  } opc_t;

  // EFLAGS with x86 bit positions, LSB is CF
  typedef struct packed {
    logic [19:0] rsvd_hi;
    logic        of_;
    logic        df_;
    logic        if_;
    logic        tf_;
    logic        sf_;
    logic        zf_;
    logic        rsvd_5;
    logic        af_;
    logic        rsvd_3;
    logic        pf_;
    logic        rsvd_1;
    logic        cf_;
  } eflags_t;

  // One decoded instruction as the host issues it
  typedef struct packed {
    opc_t                      opc;
    eflags_t                   eflags;
    logic                      ecx_is_zero;
    logic [`TINY86_LEN_W-1:0]  instr_len;
    logic [`TINY86_EIP_W-1:0]  address;
  } issue_t;

  // Retirement record, own EIP plus the resolved successor
  typedef struct packed {
    logic [`TINY86_EIP_W-1:0] eip;
    logic [`TINY86_EIP_W-1:0] next_eip;
    logic                     taken;
  } retire_t;

endpackage

/* common/tiny86_settings.svh */
// Tiny86 flow tracker widths and APB register map
// Shared by the package, the interface and the RTL blocks
`ifndef TINY86_SETTINGS_SVH
`define TINY86_SETTINGS_SVH

// EIP and address operand width
`define TINY86_EIP_W 32
// Instruction length field, in bytes
`define TINY86_LEN_W 4
// Retired and taken counters wrap at this width
`define TINY86_CNT_W 16

// APB bus geometry
`define TINY86_APB_AW 4
`define TINY86_APB_DW 32

// Word-aligned register offsets
`define TINY86_REG_EIP  4'h0
`define TINY86_REG_ICNT 4'h4
`define TINY86_REG_TCNT 4'h8
`define TINY86_REG_CTRL 4'hC

`endif

/* hdl/eip_unit.sv */
// Tiny86 EIP unit
// Owns the EIP and the retire counters and turns each issued
// instruction into a retire record through the control flow unit
`include "tiny86_settings.svh"

module eip_unit (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                in_valid,
  output logic                in_ready,
  input  tiny86_pkg::issue_t  in_data,
  output logic                out_valid,
  input  logic                out_ready,
  output tiny86_pkg::retire_t out_data,
  flow_ctrl_if.unit           ctrl
);

  logic [`TINY86_EIP_W-1:0] eip_q;
  logic [`TINY86_EIP_W-1:0] next_eip;
  logic                     taken;
  logic [`TINY86_CNT_W-1:0] icnt_q;
  logic [`TINY86_CNT_W-1:0] tcnt_q;
  logic                     step;

  cfu i_cfu (
    .opc         (in_data.opc),
    .eflags      (in_data.eflags),
    .ecx_is_zero (in_data.ecx_is_zero),
    .eip         (eip_q),
    .instr_len   (in_data.instr_len),
    .address     (in_data.address),
    .next_eip    (next_eip),
    .taken       (taken)
  );

  // No storage here, the handshake passes straight through
  assign in_ready  = out_ready;
  assign out_valid = in_valid;
  assign step      = in_valid && out_ready;

  assign out_data.eip      = eip_q;
  assign out_data.next_eip = next_eip;
  assign out_data.taken    = taken;

  // A redirect from the register block beats a same-cycle retirement
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      eip_q <= '0;
    end else if (ctrl.set_eip_valid) begin
      eip_q <= ctrl.set_eip;
    end else if (step) begin
      eip_q <= next_eip;
    end
  end

  // Counters wrap naturally; a clear beats any count in the same cycle
  always_ff @(posedge clk) begin
    if (!rst_n || ctrl.clr_counts) begin
      icnt_q <= '0;
      tcnt_q <= '0;
    end else if (step) begin
      icnt_q <= icnt_q + 1'b1;
      tcnt_q <= tcnt_q + {{(`TINY86_CNT_W-1){1'b0}}, taken};
    end
  end

  assign ctrl.eip         = eip_q;
  assign ctrl.instr_count = icnt_q;
  assign ctrl.taken_count = tcnt_q;

endmodule

/* hdl/flow_apb_regs.sv */
// APB register block for the Tiny86 flow tracker
// Decodes EIP, ICNT, TCNT and CTRL and raises redirect and clear
// pulses toward the EIP unit; zero wait states
`include "tiny86_settings.svh"

module flow_apb_regs (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      psel,
  input  logic                      penable,
  input  logic                      pwrite,
  input  logic [`TINY86_APB_AW-1:0] paddr,
  input  logic [`TINY86_APB_DW-1:0] pwdata,
  output logic [`TINY86_APB_DW-1:0] prdata,
  output logic                      pready,
  output logic                      pslverr,
  flow_ctrl_if.regs                 ctrl
);

  logic                      setup;
  logic                      hit_eip;
  logic                      hit_icnt;
  logic                      hit_tcnt;
  logic                      hit_ctrl;
  logic                      bad_access;
  logic                      set_eip_q;
  logic [`TINY86_EIP_W-1:0]  eip_wdata_q;
  logic                      clr_q;
  logic                      err_q;

  // Decisions are taken in the setup phase and land in the access phase
  assign setup = psel && !penable;

  assign hit_eip  = paddr == `TINY86_REG_EIP;
  assign hit_icnt = paddr == `TINY86_REG_ICNT;
  assign hit_tcnt = paddr == `TINY86_REG_TCNT;
  assign hit_ctrl = paddr == `TINY86_REG_CTRL;

  // Unmapped offsets and writes to the read-only counters both fail
  assign bad_access = !(hit_eip || hit_icnt || hit_tcnt || hit_ctrl) ||
                      (pwrite && (hit_icnt || hit_tcnt));

  // Pulses are high for exactly the access cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      set_eip_q <= 1'b0;
      clr_q     <= 1'b0;
      err_q     <= 1'b0;
    end else begin
      set_eip_q <= setup && pwrite && hit_eip;
      clr_q     <= setup && pwrite && hit_ctrl && pwdata[0];
      err_q     <= setup && bad_access;
    end
  end

  // Write data for a redirect is captured alongside the pulse
  always_ff @(posedge clk) begin
    if (setup && pwrite && hit_eip) begin
      eip_wdata_q <= pwdata;
    end
  end

  assign ctrl.set_eip_valid = set_eip_q;
  assign ctrl.set_eip       = eip_wdata_q;
  assign ctrl.clr_counts    = clr_q;

  // Reads see live state, CTRL reads back as zero
  always_comb begin
    prdata = '0;
    if (hit_eip) begin
      prdata = ctrl.eip;
    end else if (hit_icnt) begin
      prdata = {{(`TINY86_APB_DW-`TINY86_CNT_W){1'b0}}, ctrl.instr_count};
    end else if (hit_tcnt) begin
      prdata = {{(`TINY86_APB_DW-`TINY86_CNT_W){1'b0}}, ctrl.taken_count};
    end
  end

  assign pready  = 1'b1;
  assign pslverr = err_q;

endmodule

/* hdl/pipe_reg.sv */
// One-entry valid/ready register slice
// Payload type is a parameter so issue and retire paths share it
module pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  logic     full;
  payload_t data_q;

  // Space is available when empty or when the held entry leaves now
  assign in_ready  = !full || out_ready;
  assign out_valid = full;
  assign out_data  = data_q;

  // Occupancy follows the input whenever the slot can be refilled
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      full <= 1'b0;
    end else if (in_ready) begin
      full <= in_valid;
    end
  end

  // Payload only moves on an accepted transfer, so it holds under stall
  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      data_q <= in_data;
    end
  end

endmodule

/* hdl/tiny86_flow.sv */
// Tiny86 instruction-flow tracker top level
// Issue slice, EIP unit and retire slice in a row, with the APB
// register block alongside
`include "tiny86_settings.svh"

module tiny86_flow (
  input  logic                      clk,
  input  logic                      rst_n,
  // APB slave
  input  logic                      psel,
  input  logic                      penable,
  input  logic                      pwrite,
  input  logic [`TINY86_APB_AW-1:0] paddr,
  input  logic [`TINY86_APB_DW-1:0] pwdata,
  output logic [`TINY86_APB_DW-1:0] prdata,
  output logic                      pready,
  output logic                      pslverr,
  // Issue port
  input  logic                      issue_valid,
  output logic                      issue_ready,
  input  tiny86_pkg::opc_t          opc,
  input  tiny86_pkg::eflags_t       eflags,
  input  logic                      ecx_is_zero,
  input  logic [`TINY86_LEN_W-1:0]  instr_len,
  input  logic [`TINY86_EIP_W-1:0]  address,
  // Retire port
  output logic                      retire_valid,
  output logic [`TINY86_EIP_W-1:0]  retire_eip,
  output logic [`TINY86_EIP_W-1:0]  retire_next_eip,
  output logic                      retire_taken,
  input  logic                      retire_ready
);

  tiny86_pkg::issue_t  issue_in;
  tiny86_pkg::issue_t  issue_q;
  tiny86_pkg::retire_t retire_d;
  tiny86_pkg::retire_t retire_q;
  logic                issue_q_valid;
  logic                issue_q_ready;
  logic                retire_d_valid;
  logic                retire_d_ready;

  flow_ctrl_if i_ctrl_if ();

  // Gather the plain issue ports into one payload
  assign issue_in.opc         = opc;
  assign issue_in.eflags      = eflags;
  assign issue_in.ecx_is_zero = ecx_is_zero;
  assign issue_in.instr_len   = instr_len;
  assign issue_in.address     = address;

  pipe_reg #(.payload_t(tiny86_pkg::issue_t)) i_issue_slice (
    .clk, .rst_n,
    .in_valid  (issue_valid),    .in_ready  (issue_ready),    .in_data  (issue_in),
    .out_valid (issue_q_valid),  .out_ready (issue_q_ready),  .out_data (issue_q)
  );

  eip_unit i_eip_unit (
    .clk, .rst_n,
    .in_valid  (issue_q_valid),  .in_ready  (issue_q_ready),  .in_data  (issue_q),
    .out_valid (retire_d_valid), .out_ready (retire_d_ready), .out_data (retire_d),
    .ctrl      (i_ctrl_if.unit)
  );

  pipe_reg #(.payload_t(tiny86_pkg::retire_t)) i_retire_slice (
    .clk, .rst_n,
    .in_valid  (retire_d_valid), .in_ready  (retire_d_ready), .in_data  (retire_d),
    .out_valid (retire_valid),   .out_ready (retire_ready),   .out_data (retire_q)
  );

  flow_apb_regs i_apb_regs (
    .clk, .rst_n, .psel, .penable, .pwrite, .paddr, .pwdata,
    .prdata, .pready, .pslverr,
    .ctrl (i_ctrl_if.regs)
  );

  // Spread the retire record back onto plain ports
  assign retire_eip      = retire_q.eip;
  assign retire_next_eip = retire_q.next_eip;
  assign retire_taken    = retire_q.taken;

endmodule

/* tb/tiny86_flow_tb.sv */
// Tiny86 flow tracker testbench
// Drives a random issue stream into the DUT, predicts every retire record
// with a reference model, and covers the APB register map and error responses
`include "tiny86_settings.svh"

module tiny86_flow_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD = 8;
  localparam int LEN_W = `TINY86_LEN_W;
  // Instructions per phase and APB accesses over the whole run
  localparam int N_SEQ = 60;
  localparam int N_JCC = 160;
  localparam int N_FLOW = 100;
  localparam int N_REDIR = 20;
  localparam int N_MIX = 200;
  localparam int N_APB = 32;
  localparam int TIMEOUT_CYCLES = 10 * (N_SEQ + N_JCC + N_FLOW + N_REDIR + N_MIX + N_APB);
  localparam logic [`TINY86_APB_AW-1:0] UNMAPPED [4] = '{4'h1, 4'h6, 4'hB, 4'hF};

  logic                      clk = 1'b0;
  logic                      rst_n;
  logic                      psel;
  logic                      penable;
  logic                      pwrite;
  logic [`TINY86_APB_AW-1:0] paddr;
  logic [`TINY86_APB_DW-1:0] pwdata;
  logic [`TINY86_APB_DW-1:0] prdata;
  logic                      pready;
  logic                      pslverr;
  logic                      issue_valid;
  logic                      issue_ready;
  tiny86_pkg::opc_t          opc;
  tiny86_pkg::eflags_t       eflags;
  logic                      ecx_is_zero;
  logic [LEN_W-1:0]          instr_len;
  logic [`TINY86_EIP_W-1:0]  address;
  logic                      retire_valid;
  logic [`TINY86_EIP_W-1:0]  retire_eip;
  logic [`TINY86_EIP_W-1:0]  retire_next_eip;
  logic                      retire_taken;
  logic                      retire_ready;

  // Reference model state, expected records wait here in issue order
  tiny86_pkg::retire_t      expect_q [$];
  tiny86_pkg::retire_t      seen;
  logic [`TINY86_EIP_W-1:0] model_eip = '0;
  logic [`TINY86_CNT_W-1:0] model_icnt = '0;
  logic [`TINY86_CNT_W-1:0] model_tcnt = '0;
  logic [31:0]              rng_state = 32'h24dfa74f;
  logic                     stall_mode = 1'b0;
  int                       issued = 0;
  int                       retired = 0;
  int                       retire_errors = 0;
  int                       reg_errors = 0;
  int                       flag_errors = 0;
  int                       other_errors = 0;

  tiny86_flow i_dut (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Numerical Recipes constants for the LCG
  function automatic logic [31:0] lcg_next();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  // The low LCG bits are weak, so draw from the upper ones
  function automatic int unsigned rand_below(input int unsigned n);
    logic [31:0] r;
    r = lcg_next();
    return {8'h00, r[31:8]} % n;
  endfunction

  // Kind 0 is NOP/ALU, 1 is Jcc, 2 is loop and unconditional, 3 is any opcode
  function automatic tiny86_pkg::issue_t make_instr(input int kind);
    tiny86_pkg::issue_t ins;
    int                 code;
    case (kind)
      0: code = int'(tiny86_pkg::CMD_NOP) + int'(rand_below(2));
      1: code = int'(tiny86_pkg::CMD_JO) + int'(rand_below(16));
      2: code = int'(tiny86_pkg::CMD_JCXZ) + int'(rand_below(9));
      default: code = int'(rand_below(int'(tiny86_pkg::CMD_RET) + 1));
    endcase
    ins.opc         = tiny86_pkg::opc_t'(code[6:0]);
    ins.eflags      = tiny86_pkg::eflags_t'(lcg_next());
    ins.ecx_is_zero = rand_below(2) == 0;
    ins.instr_len   = LEN_W'(rand_below(15) + 1);
    ins.address     = lcg_next();
    return ins;
  endfunction

  // Next EIP from x86 semantics, flags read by their architectural bit positions
  function automatic tiny86_pkg::retire_t predict(input tiny86_pkg::issue_t ins,
                                                  input logic [`TINY86_EIP_W-1:0] eip);
    tiny86_pkg::retire_t      rec;
    logic [31:0]              fl;
    logic [`TINY86_EIP_W-1:0] seq;
    logic                     go;
    logic                     absolute;
    int                       cc;
    fl       = ins.eflags;
    seq      = eip + `TINY86_EIP_W'(ins.instr_len);
    go       = 1'b0;
    absolute = 1'b0;
    if (ins.opc >= tiny86_pkg::CMD_JO && ins.opc <= tiny86_pkg::CMD_JG) begin
      // Condition codes come in pairs, the odd one of a pair is the negation
      cc = int'(ins.opc) - int'(tiny86_pkg::CMD_JO);
      case (cc / 2)
        0: go = fl[11];
        1: go = fl[0];
        2: go = fl[6];
        3: go = fl[0] | fl[6];
        4: go = fl[7];
        5: go = fl[2];
        6: go = fl[7] ^ fl[11];
        default: go = fl[6] | (fl[7] ^ fl[11]);
      endcase
      go = go ^ cc[0];
    end else begin
      case (ins.opc)
        tiny86_pkg::CMD_JCXZ:   go = ins.ecx_is_zero;
        tiny86_pkg::CMD_LOOP:   go = !ins.ecx_is_zero;
        tiny86_pkg::CMD_LOOPE:  go = !ins.ecx_is_zero && fl[6];
        tiny86_pkg::CMD_LOOPNE: go = !ins.ecx_is_zero && !fl[6];
        tiny86_pkg::CMD_CALLr, tiny86_pkg::CMD_JMPr: go = 1'b1;
        tiny86_pkg::CMD_CALLi, tiny86_pkg::CMD_JMPi, tiny86_pkg::CMD_RET: begin
          go       = 1'b1;
          absolute = 1'b1;
        end
        default: go = 1'b0;
      endcase
    end
    rec.eip      = eip;
    rec.taken    = go;
    rec.next_eip = !go ? seq : (absolute ? ins.address : seq + ins.address);
    return rec;
  endfunction

  task automatic check_retire(input tiny86_pkg::retire_t got, input tiny86_pkg::retire_t exp);
    if (got !== exp) begin
      retire_errors++;
      $display("Error at %0t: retire_eip/next_eip/taken got %h/%h/%b, expected %h/%h/%b",
               $time, got.eip, got.next_eip, got.taken, exp.eip, exp.next_eip, exp.taken);
    end
  endtask

  task automatic check_reg(input string name, input logic [`TINY86_APB_DW-1:0] got,
                           input logic [`TINY86_APB_DW-1:0] exp);
    if (got !== exp) begin
      reg_errors++;
      $display("Error at %0t: %s read 0x%08h, expected 0x%08h", $time, name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      flag_errors++;
      $display("Error at %0t: %s is %b, expected %b", $time, name, got, exp);
    end
  endtask

  // Back-pressure draw, one per falling edge while stalls are on
  task automatic update_retire_ready();
    retire_ready = stall_mode ? (rand_below(5) >= 2) : 1'b1;
  endtask

  // Record the instruction in the model on the edge it is accepted
  task automatic accept(input tiny86_pkg::issue_t ins);
    tiny86_pkg::retire_t rec;
    rec = predict(ins, model_eip);
    expect_q.push_back(rec);
    model_eip  = rec.next_eip;
    model_icnt += 16'd1;
    if (rec.taken) begin
      model_tcnt += 16'd1;
    end
    issued++;
  endtask

  task automatic issue_instr(input tiny86_pkg::issue_t ins);
    // An idle cycle now and then between instructions
    if (rand_below(4) == 0) begin
      @(negedge clk);
      issue_valid = 1'b0;
      update_retire_ready();
    end
    @(negedge clk);
    issue_valid = 1'b1;
    opc         = ins.opc;
    eflags      = ins.eflags;
    ecx_is_zero = ins.ecx_is_zero;
    instr_len   = ins.instr_len;
    address     = ins.address;
    update_retire_ready();
    @(posedge clk);
    while (!issue_ready) begin
      @(negedge clk);
      update_retire_ready();
      @(posedge clk);
    end
    accept(ins);
  endtask

  // Issue a block, then let every outstanding record retire
  task automatic run_phase(input int kind, input int count);
    for (int i = 0; i < count; i++) begin
      issue_instr(make_instr(kind));
    end
    @(negedge clk);
    issue_valid = 1'b0;
    while (expect_q.size() != 0) begin
      @(negedge clk);
      update_retire_ready();
    end
    retire_ready = 1'b1;
  endtask

  // Two-phase APB transfer, response sampled on the edge that ends the access phase
  task automatic apb_access(input logic wr, input logic [`TINY86_APB_AW-1:0] addr,
                            input logic [`TINY86_APB_DW-1:0] wdata,
                            output logic [`TINY86_APB_DW-1:0] rdata, output logic err);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge clk);
    penable = 1'b1;
    @(posedge clk);
    rdata = prdata;
    err   = pslverr;
    // Zero wait states, so every access phase completes on its first edge
    check_flag("pready in access phase", pready, 1'b1);
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_read(input string name, input logic [`TINY86_APB_AW-1:0] addr,
                          input logic [`TINY86_APB_DW-1:0] exp, input logic exp_err);
    logic [`TINY86_APB_DW-1:0] rdata;
    logic                      err;
    apb_access(1'b0, addr, '0, rdata, err);
    check_flag({"pslverr on read of ", name}, err, exp_err);
    if (!exp_err) begin
      check_reg(name, rdata, exp);
    end
  endtask

  task automatic apb_write(input string name, input logic [`TINY86_APB_AW-1:0] addr,
                           input logic [`TINY86_APB_DW-1:0] data, input logic exp_err);
    logic [`TINY86_APB_DW-1:0] rdata;
    logic                      err;
    apb_access(1'b1, addr, data, rdata, err);
    check_flag({"pslverr on write of ", name}, err, exp_err);
  endtask

  task automatic check_counts();
    apb_read("ICNT", `TINY86_REG_ICNT, `TINY86_APB_DW'(model_icnt), 1'b0);
    apb_read("TCNT", `TINY86_REG_TCNT, `TINY86_APB_DW'(model_tcnt), 1'b0);
  endtask

  // Every accepted retire record must match the oldest prediction
  always @(posedge clk) begin
    if (rst_n && retire_valid && retire_ready) begin
      seen = '{eip: retire_eip, next_eip: retire_next_eip, taken: retire_taken};
      retired++;
      if (expect_q.size() == 0) begin
        other_errors++;
        $display("At %0t a retire record came out with no instruction outstanding", $time);
      end else begin
        check_retire(seen, expect_q.pop_front());
      end
    end
  end

  initial begin : watchdog
    int unsigned cycles;
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d cycles", cycles);
    $display("Test failures found");
    $finish;
  end

  initial begin
    logic [`TINY86_EIP_W-1:0] target;
    rst_n        = 1'b0;
    psel         = 1'b0;
    penable      = 1'b0;
    pwrite       = 1'b0;
    paddr        = '0;
    pwdata       = '0;
    issue_valid  = 1'b0;
    opc          = tiny86_pkg::CMD_NOP;
    eflags       = '0;
    ecx_is_zero  = 1'b0;
    instr_len    = '0;
    address      = '0;
    retire_ready = 1'b1;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    @(posedge clk);
    check_flag("retire_valid after reset", retire_valid, 1'b0);
    check_flag("issue_ready after reset", issue_ready, 1'b1);
    check_flag("pslverr after reset", pslverr, 1'b0);
    apb_read("EIP", `TINY86_REG_EIP, '0, 1'b0);
    check_counts();

    // Sequential flow, then every Jcc, then loops and unconditional transfers
    run_phase(0, N_SEQ);
    check_counts();
    run_phase(1, N_JCC);
    check_counts();
    run_phase(2, N_FLOW);
    check_counts();

    // Redirect while idle, the next instruction must start at the new EIP
    target = lcg_next();
    apb_write("EIP", `TINY86_REG_EIP, target, 1'b0);
    model_eip = target;
    apb_read("EIP", `TINY86_REG_EIP, target, 1'b0);
    run_phase(3, N_REDIR);
    apb_read("EIP", `TINY86_REG_EIP, model_eip, 1'b0);
    check_counts();

    // Mixed opcodes under random retire stalls
    stall_mode = 1'b1;
    run_phase(3, N_MIX);
    stall_mode = 1'b0;
    apb_read("EIP", `TINY86_REG_EIP, model_eip, 1'b0);
    check_counts();

    apb_write("CTRL", `TINY86_REG_CTRL, 32'h1, 1'b0);
    model_icnt = '0;
    model_tcnt = '0;
    check_counts();

    // Unmapped offsets and counter writes fail and leave the counters alone
    for (int i = 0; i < 4; i++) begin
      apb_read("unmapped", UNMAPPED[i], '0, 1'b1);
      apb_write("unmapped", UNMAPPED[i], lcg_next(), 1'b1);
    end
    apb_write("ICNT", `TINY86_REG_ICNT, lcg_next(), 1'b1);
    apb_write("TCNT", `TINY86_REG_TCNT, lcg_next(), 1'b1);
    check_counts();

    if (issued != retired) begin
      other_errors++;
      $display("%0d instructions were issued but %0d records retired", issued, retired);
    end
    $display("Summary: %0d issued, %0d retired, errors %0d retire %0d register %0d flag %0d other",
             issued, retired, retire_errors, reg_errors, flag_errors, other_errors);
    if (retire_errors + reg_errors + flag_errors + other_errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

/* tiny86_flow.f */
+incdir+common
common/tiny86_pkg.sv
common/flow_ctrl_if.sv
hdl/pipe_reg.sv
cfu/cfu.sv
hdl/eip_unit.sv
hdl/flow_apb_regs.sv
hdl/tiny86_flow.sv
tb/tiny86_flow_tb.sv
